/* include/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// cause codes, as in the MIPS32 cause register
`define EXCCODE_ADEL 5'h04
`define EXCCODE_ADES 5'h05
`define EXCCODE_SYS  5'h08
`define EXCCODE_BP   5'h09
`define EXCCODE_RI   5'h0a
`define EXCCODE_OV   5'h0c
`define EXCCODE_TR   5'h0d

// radix-2 divider, one quotient bit per step
`define DIV_STEPS 32

`endif

/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

typedef enum logic [5:0] {
	OP_INVALID,
	OP_AND, OP_OR, OP_XOR, OP_NOR, OP_LUI,
	OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
	OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV,
	OP_SLT, OP_SLTU, OP_CLZ, OP_CLO, OP_MOVZ, OP_MOVN,
	OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
	OP_MUL, OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
	OP_TEQ, OP_TNE, OP_TGE, OP_TLT, OP_TGEU, OP_TLTU,
	OP_SYSCALL, OP_BREAK,
	OP_BEQ, OP_BNE, OP_BLTZ, OP_BGEZ, OP_BGTZ, OP_BLEZ, OP_BLTZAL, OP_BGEZAL,
	OP_J, OP_JAL, OP_JR, OP_JALR,
	OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW
} oper_t;

// same word seen as R format or I format
typedef union packed {
	struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r;
	struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} i;
} instr_t;

typedef struct packed {
	logic        valid;
	logic [4:0]  exc_code;
	logic [31:0] extra;
} exception_t;

typedef struct packed {
	logic        read;
	logic        write;
	logic [31:0] vaddr;
	logic [3:0]  byteenable;
	logic [31:0] wrdata;
} mem_req_t;

typedef struct packed {
	logic        valid;
	logic        taken;
	logic [31:0] target;
} branch_resolved_t;

typedef struct packed {
	logic             valid;
	logic [31:0]      pc;
	logic [4:0]       rd;
	logic [31:0]      result;
	exception_t       ex;
	mem_req_t         memreq;
	branch_resolved_t branch;
} exec_result_t;

endpackage

`default_nettype wire

/* verilog/muldiv_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface muldiv_if;
import cpu_pkg::*;

logic        start;
oper_t       op;
logic [31:0] a;
logic [31:0] b;
logic        busy;
// {hi, lo}
logic [63:0] hilo;
logic [31:0] mul_word;

modport exec (
	output start, op, a, b,
	input  busy, hilo, mul_word
);

modport unit (
	input  start, op, a, b,
	output busy, hilo, mul_word
);

endinterface

`default_nettype wire

/* verilog/count_bit.sv */
`timescale 1ns/1ps
`default_nettype none

module count_bit (
	input  logic        bit_val,
	input  logic [31:0] val,
	output logic [5:0]  count
);

always_comb begin
	count = 6'd32;
	// last write wins, so the highest mismatch sets the count
	for (int i = 0; i < 32; i++) begin
		if (val[i] != bit_val)
			count = 6'(31 - i);
	end
end

endmodule

`default_nettype wire

/* verilog/multi_cycle_exec.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module multi_cycle_exec #(
	parameter int HAS_DIV = 1
) (
	input  logic        clk,
	input  logic        rst,
	muldiv_if.unit      port,
	input  logic        mthi_we,
	input  logic        mtlo_we,
	input  logic [31:0] mt_wdata
);
import cpu_pkg::*;

localparam logic [2:0] S_IDLE = 3'd0;
localparam logic [2:0] S_MUL1 = 3'd1;
localparam logic [2:0] S_MUL2 = 3'd2;
localparam logic [2:0] S_DIV  = 3'd3;
localparam logic [2:0] S_FIX  = 3'd4;

logic [2:0]  state;
logic [5:0]  step;
logic [31:0] hi;
logic [31:0] lo;
// opa doubles as dividend / quotient shift register
logic [31:0] opa;
logic [31:0] opb;
logic        is_signed;
logic [63:0] prod;
logic [31:0] rem;
logic [32:0] rem_shift;
logic        neg_q;
logic        neg_r;
logic        div_zero;
logic        do_mul;
logic        do_div;
logic        div_signed;

assign do_mul = port.op == OP_MULT || port.op == OP_MULTU;
assign do_div = HAS_DIV != 0 && (port.op == OP_DIV || port.op == OP_DIVU);
assign div_signed = port.op == OP_DIV;
assign rem_shift = {rem, opa[31]};

assign port.busy = state != S_IDLE;
assign port.hilo = {hi, lo};
// low word is the same for signed and unsigned
assign port.mul_word = port.a * port.b;

always_ff @(posedge clk) begin
	if (rst) begin
		state <= S_IDLE;
		step  <= '0;
		hi    <= '0;
		lo    <= '0;
	end else begin
		case (state)
			S_IDLE: begin
				if (mthi_we)
					hi <= mt_wdata;
				if (mtlo_we)
					lo <= mt_wdata;
				if (port.start && do_mul) begin
					opa       <= port.a;
					opb       <= port.b;
					is_signed <= port.op == OP_MULT;
					state     <= S_MUL1;
				end else if (port.start && do_div) begin
					// divide magnitudes, fix signs at the end
					opa      <= (div_signed && port.a[31]) ? -port.a : port.a;
					opb      <= (div_signed && port.b[31]) ? -port.b : port.b;
					neg_q    <= div_signed && (port.a[31] ^ port.b[31]);
					neg_r    <= div_signed && port.a[31];
					div_zero <= port.b == '0;
					rem      <= '0;
					step     <= '0;
					state    <= S_DIV;
				end
			end
			S_MUL1: begin
				if (is_signed)
					prod <= $signed(opa) * $signed(opb);
				else
					prod <= opa * opb;
				state <= S_MUL2;
			end
			S_MUL2: begin
				hi    <= prod[63:32];
				lo    <= prod[31:0];
				state <= S_IDLE;
			end
			S_DIV: begin
				if (rem_shift >= {1'b0, opb}) begin
					rem <= 32'(rem_shift - {1'b0, opb});
					opa <= {opa[30:0], 1'b1};
				end else begin
					rem <= rem_shift[31:0];
					opa <= {opa[30:0], 1'b0};
				end
				step <= step + 6'd1;
				if (step == 6'(`DIV_STEPS - 1))
					state <= S_FIX;
			end
			S_FIX: begin
				// divide by zero keeps the old HI/LO
				if (!div_zero) begin
					hi <= neg_r ? -rem : rem;
					lo <= neg_q ? -opa : opa;
				end
				state <= S_IDLE;
			end
			default: state <= S_IDLE;
		endcase
	end
end

endmodule

`default_nettype wire

/* verilog/branch_resolver.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_resolver (
	input  cpu_pkg::oper_t            op,
	input  logic [31:0]               pc,
	input  logic [31:0]               reg1,
	input  logic [31:0]               reg2,
	input  cpu_pkg::instr_t           instr,
	output cpu_pkg::branch_resolved_t resolved
);
import cpu_pkg::*;

logic [31:0] pc4;
logic [31:0] br_target;
logic        reg1_zero;

assign pc4 = pc + 32'd4;
assign br_target = pc4 + {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};
assign reg1_zero = reg1 == '0;

always_comb begin
	resolved.valid  = 1'b1;
	resolved.taken  = 1'b0;
	resolved.target = br_target;
	case (op)
		OP_BEQ:             resolved.taken = reg1 == reg2;
		OP_BNE:             resolved.taken = reg1 != reg2;
		OP_BLTZ, OP_BLTZAL: resolved.taken = reg1[31];
		OP_BGEZ, OP_BGEZAL: resolved.taken = ~reg1[31];
		OP_BGTZ:            resolved.taken = ~reg1[31] & ~reg1_zero;
		OP_BLEZ:            resolved.taken = reg1[31] | reg1_zero;
		OP_J, OP_JAL: begin
			// stays inside the current 256 MB region
			resolved.taken  = 1'b1;
			resolved.target = {pc4[31:28], instr[25:0], 2'b00};
		end
		OP_JR, OP_JALR: begin
			resolved.taken  = 1'b1;
			resolved.target = reg1;
		end
		default: resolved.valid = 1'b0;
	endcase
end

endmodule

`default_nettype wire

/* verilog/instr_exec.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module instr_exec #(
	parameter int HAS_DIV = 1
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      in_valid,
	input  cpu_pkg::oper_t            op,
	input  cpu_pkg::instr_t           instr,
	input  logic [31:0]               pc,
	input  logic [31:0]               reg1,
	input  logic [31:0]               reg2,
	muldiv_if.exec                    md,
	output logic                      mthi_we,
	output logic                      mtlo_we,
	output logic [31:0]               mt_wdata,
	input  logic [5:0]                clz_cnt,
	input  logic [5:0]                clo_cnt,
	input  cpu_pkg::branch_resolved_t branch,
	output cpu_pkg::exec_result_t     result
);
import cpu_pkg::*;

logic         accept;
logic         invalid;
logic [31:0]  add_u;
logic [31:0]  sub_u;
logic [31:0]  vaddr;
logic [31:0]  exec_ret;
logic         ov;
logic         signed_lt;
logic         unsigned_lt;
logic         is_load;
logic         trap_valid;
logic         addr_err;
logic [4:0]   rd;
exception_t   ex;
mem_req_t     memreq;
exec_result_t nxt;

assign accept = in_valid & ~md.busy;
assign invalid = op == OP_INVALID || (HAS_DIV == 0 && (op == OP_DIV || op == OP_DIVU));

assign md.start = accept & ~invalid & (op inside {OP_MULT, OP_MULTU, OP_DIV, OP_DIVU});
assign md.op = op;
assign md.a = reg1;
assign md.b = reg2;
assign mthi_we = accept & (op == OP_MTHI);
assign mtlo_we = accept & (op == OP_MTLO);
assign mt_wdata = reg1;

assign add_u = reg1 + reg2;
assign sub_u = reg1 - reg2;
assign ov = (op == OP_ADD && reg1[31] == reg2[31] && reg1[31] != add_u[31])
	|| (op == OP_SUB && reg1[31] != reg2[31] && reg1[31] != sub_u[31]);
assign signed_lt = (reg1[31] != reg2[31]) ? reg1[31] : sub_u[31];
assign unsigned_lt = reg1 < reg2;

always_comb begin
	case (op)
		OP_LUI:  exec_ret = {instr.i.imm16, 16'h0000};
		OP_AND:  exec_ret = reg1 & reg2;
		OP_OR:   exec_ret = reg1 | reg2;
		OP_XOR:  exec_ret = reg1 ^ reg2;
		OP_NOR:  exec_ret = ~(reg1 | reg2);
		OP_ADD, OP_ADDU: exec_ret = add_u;
		OP_SUB, OP_SUBU: exec_ret = sub_u;
		OP_SLL:  exec_ret = reg2 << instr.r.shamt;
		OP_SLLV: exec_ret = reg2 << reg1[4:0];
		OP_SRL:  exec_ret = reg2 >> instr.r.shamt;
		OP_SRLV: exec_ret = reg2 >> reg1[4:0];
		OP_SRA:  exec_ret = $signed(reg2) >>> instr.r.shamt;
		OP_SRAV: exec_ret = $signed(reg2) >>> reg1[4:0];
		OP_SLT:  exec_ret = {31'd0, signed_lt};
		OP_SLTU: exec_ret = {31'd0, unsigned_lt};
		OP_CLZ:  exec_ret = {26'd0, clz_cnt};
		OP_CLO:  exec_ret = {26'd0, clo_cnt};
		OP_MOVZ, OP_MOVN: exec_ret = reg1;
		OP_MFHI: exec_ret = md.hilo[63:32];
		OP_MFLO: exec_ret = md.hilo[31:0];
		OP_MUL:  exec_ret = md.mul_word;
		// link skips the delay slot
		OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL: exec_ret = pc + 32'd8;
		default: exec_ret = '0;
	endcase
end

// memory request
assign vaddr = reg1 + {{16{instr.i.imm16[15]}}, instr.i.imm16};
assign is_load = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};

always_comb begin
	memreq.read       = is_load;
	memreq.vaddr      = vaddr;
	memreq.wrdata     = '0;
	memreq.byteenable = 4'b0000;
	addr_err          = 1'b0;
	case (op)
		OP_LB, OP_LBU, OP_SB: begin
			memreq.wrdata     = reg2 << {vaddr[1:0], 3'b000};
			memreq.byteenable = 4'b0001 << vaddr[1:0];
		end
		OP_LH, OP_LHU, OP_SH: begin
			memreq.wrdata     = vaddr[1] ? {reg2[15:0], 16'h0000} : reg2;
			memreq.byteenable = vaddr[1] ? 4'b1100 : 4'b0011;
			addr_err          = vaddr[0];
		end
		OP_LW, OP_SW: begin
			memreq.wrdata     = reg2;
			memreq.byteenable = 4'b1111;
			addr_err          = |vaddr[1:0];
		end
		default: ;
	endcase
	memreq.write = (op inside {OP_SB, OP_SH, OP_SW}) & ~addr_err;
end

always_comb begin
	case (op)
		OP_TEQ:  trap_valid = reg1 == reg2;
		OP_TNE:  trap_valid = reg1 != reg2;
		OP_TGE:  trap_valid = ~signed_lt;
		OP_TLT:  trap_valid = signed_lt;
		OP_TGEU: trap_valid = ~unsigned_lt;
		OP_TLTU: trap_valid = unsigned_lt;
		default: trap_valid = 1'b0;
	endcase
end

// exception priority
always_comb begin
	ex = '0;
	ex.valid = invalid | trap_valid | ov | addr_err
		| (op == OP_BREAK) | (op == OP_SYSCALL);
	if (invalid)
		ex.exc_code = `EXCCODE_RI;
	else if (trap_valid)
		ex.exc_code = `EXCCODE_TR;
	else if (op == OP_BREAK)
		ex.exc_code = `EXCCODE_BP;
	else if (op == OP_SYSCALL)
		ex.exc_code = `EXCCODE_SYS;
	else if (ov)
		ex.exc_code = `EXCCODE_OV;
	else if (addr_err) begin
		ex.exc_code = is_load ? `EXCCODE_ADEL : `EXCCODE_ADES;
		ex.extra    = vaddr;
	end
end

// destination register, zero when nothing is written
always_comb begin
	case (op)
		OP_LUI, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: rd = instr.i.rt;
		OP_JAL, OP_BLTZAL, OP_BGEZAL: rd = 5'd31;
		OP_MOVZ: rd = (reg2 == '0) ? instr.r.rd : 5'd0;
		OP_MOVN: rd = (reg2 != '0) ? instr.r.rd : 5'd0;
		OP_AND, OP_OR, OP_XOR, OP_NOR, OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
		OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV, OP_SLT, OP_SLTU,
		OP_CLZ, OP_CLO, OP_MFHI, OP_MFLO, OP_MUL, OP_JALR:
			rd = instr.r.rd;
		default: rd = 5'd0;
	endcase
	if (ex.valid)
		rd = 5'd0;
end

always_comb begin
	nxt.valid  = 1'b1;
	nxt.pc     = pc;
	nxt.rd     = rd;
	nxt.result = exec_ret;
	nxt.ex     = ex;
	nxt.memreq = memreq;
	nxt.branch = branch;
end

always_ff @(posedge clk) begin
	if (accept)
		result <= nxt;
	if (rst)
		result.valid <= 1'b0;
	else
		result.valid <= accept;
end

endmodule

`default_nettype wire

/* verilog/exec_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_stage_top #(
	parameter int HAS_DIV = 1
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           in_valid,
	input  cpu_pkg::oper_t in_op,
	input  logic [31:0]    in_instr,
	input  logic [31:0]    in_pc,
	input  logic [31:0]    in_reg1,
	input  logic [31:0]    in_reg2,
	output logic           stall,
	output logic           out_valid,
	output logic [4:0]     out_rd,
	output logic [31:0]    out_result,
	output logic           out_exc_valid,
	output logic [4:0]     out_exc_code,
	output logic [31:0]    out_exc_extra,
	output logic           out_mem_read,
	output logic           out_mem_write,
	output logic [31:0]    out_mem_addr,
	output logic [31:0]    out_mem_wdata,
	output logic [3:0]     out_mem_be,
	output logic           out_br_valid,
	output logic           out_br_taken,
	output logic [31:0]    out_br_target
);
import cpu_pkg::*;

muldiv_if         md ();
logic [5:0]       clz_cnt;
logic [5:0]       clo_cnt;
branch_resolved_t branch;
exec_result_t     res;
logic             mthi_we;
logic             mtlo_we;
logic [31:0]      mt_wdata;

count_bit u_clz (
	.bit_val ( 1'b0    ),
	.val     ( in_reg1 ),
	.count   ( clz_cnt )
);

count_bit u_clo (
	.bit_val ( 1'b1    ),
	.val     ( in_reg1 ),
	.count   ( clo_cnt )
);

branch_resolver u_branch (
	.op       ( in_op    ),
	.pc       ( in_pc    ),
	.reg1     ( in_reg1  ),
	.reg2     ( in_reg2  ),
	.instr    ( in_instr ),
	.resolved ( branch   )
);

instr_exec #(
	.HAS_DIV ( HAS_DIV )
) u_exec (
	.clk,
	.rst,
	.in_valid,
	.op       ( in_op    ),
	.instr    ( in_instr ),
	.pc       ( in_pc    ),
	.reg1     ( in_reg1  ),
	.reg2     ( in_reg2  ),
	.md       ( md.exec  ),
	.mthi_we,
	.mtlo_we,
	.mt_wdata,
	.clz_cnt,
	.clo_cnt,
	.branch,
	.result   ( res      )
);

multi_cycle_exec #(
	.HAS_DIV ( HAS_DIV )
) u_muldiv (
	.clk,
	.rst,
	.port     ( md.unit  ),
	.mthi_we,
	.mtlo_we,
	.mt_wdata
);

assign stall         = md.busy;
assign out_valid     = res.valid;
assign out_rd        = res.rd;
assign out_result    = res.result;
assign out_exc_valid = res.ex.valid;
assign out_exc_code  = res.ex.exc_code;
assign out_exc_extra = res.ex.extra;
assign out_mem_read  = res.memreq.read;
assign out_mem_write = res.memreq.write;
assign out_mem_addr  = res.memreq.vaddr;
assign out_mem_wdata = res.memreq.wrdata;
assign out_mem_be    = res.memreq.byteenable;
assign out_br_valid  = res.branch.valid;
assign out_br_taken  = res.branch.taken;
assign out_br_target = res.branch.target;

endmodule

`default_nettype wire

/* verification/exec_stage_props.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module exec_stage_props (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic stall,
	input logic out_valid
);

// consecutive cycles with stall high
int stall_run;

always_ff @(posedge clk) begin
	if (rst || !stall)
		stall_run <= 0;
	else
		stall_run <= stall_run + 1;
end

valid_low_in_reset: assert property (@(posedge clk) rst |=> !out_valid)
	else $error("out_valid high after a reset cycle");

no_accept_while_stalled: assert property (@(posedge clk) disable iff (rst)
	(in_valid && stall) |=> !out_valid)
	else $error("instruction accepted while stall was high");

stall_bounded: assert property (@(posedge clk) disable iff (rst)
	stall_run <= `DIV_STEPS + 1)
	else $error("stall held longer than the divider needs");

endmodule

`default_nettype wire

/* verification/exec_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module exec_stage_tb;
import cpu_pkg::*;

localparam int CLK_PERIOD = 8;
localparam int N_OPS = 40;
// six tests, and muldiv_hilo issues three ops per draw
localparam int TOTAL_OPS = N_OPS * 8;
localparam int TIMEOUT_NS = TOTAL_OPS * (`DIV_STEPS + 4) * CLK_PERIOD + 500;

logic        clk;
logic        rst;
logic        in_valid;
oper_t       in_op;
logic [31:0] in_instr;
logic [31:0] in_pc;
logic [31:0] in_reg1;
logic [31:0] in_reg2;
logic        stall;
logic        out_valid;
logic [4:0]  out_rd;
logic [31:0] out_result;
logic        out_exc_valid;
logic [4:0]  out_exc_code;
logic [31:0] out_exc_extra;
logic        out_mem_read;
logic        out_mem_write;
logic [31:0] out_mem_addr;
logic [31:0] out_mem_wdata;
logic [3:0]  out_mem_be;
logic        out_br_valid;
logic        out_br_taken;
logic [31:0] out_br_target;

// reference model state and expected outputs
logic [31:0] m_hi;
logic [31:0] m_lo;
logic        has_res;
logic [31:0] e_res;
logic [4:0]  e_rd;
logic        e_exc;
logic [4:0]  e_code;
logic [31:0] e_extra;
logic        use_mem;
logic        is_store;
logic        e_read;
logic        e_write;
logic [31:0] e_addr;
logic [3:0]  e_be;
logic [31:0] e_wdata;
logic        e_br_valid;
logic        e_taken;
logic [31:0] e_target;
int          e_stall;

string cur_test;
int    checks;
int    errors;

oper_t alu_set [21] = '{OP_AND, OP_OR, OP_XOR, OP_NOR, OP_LUI, OP_ADD, OP_ADDU,
	OP_SUB, OP_SUBU, OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV,
	OP_SLT, OP_SLTU, OP_CLZ, OP_CLO, OP_MOVZ, OP_MOVN};
oper_t md_set [7] = '{OP_MUL, OP_MULT, OP_MULTU, OP_DIV, OP_DIVU, OP_MTHI, OP_MTLO};
oper_t mem_set [8] = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW};
oper_t br_set [12] = '{OP_BEQ, OP_BNE, OP_BLTZ, OP_BGEZ, OP_BGTZ, OP_BLEZ,
	OP_BLTZAL, OP_BGEZAL, OP_J, OP_JAL, OP_JR, OP_JALR};
oper_t exc_set [9] = '{OP_TEQ, OP_TNE, OP_TGE, OP_TLT, OP_TGEU, OP_TLTU,
	OP_SYSCALL, OP_BREAK, OP_INVALID};

exec_stage_top dut (.*);

bind exec_stage_top exec_stage_props u_props (
	.clk       ( clk       ),
	.rst       ( rst       ),
	.in_valid  ( in_valid  ),
	.stall     ( stall     ),
	.out_valid ( out_valid )
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

initial begin
	#(TIMEOUT_NS);
	$display("watchdog: run still busy after %0d ns, a handshake never completed",
		TIMEOUT_NS);
	$display("=== FAIL ===");
	$finish;
end

function automatic logic [31:0] rand_operand();
	case ($urandom % 8)
		0: return 32'd0;
		1: return 32'hffff_ffff;
		2: return 32'h8000_0000;
		3: return $urandom % 16;
		4: return $urandom >> ($urandom % 32);
		5: return ~($urandom >> ($urandom % 32));
		default: return $urandom;
	endcase
endfunction

function automatic oper_t pick_op(input int kind);
	int k;
	k = (kind == 5) ? int'($urandom % 5) : kind;
	case (k)
		0: return alu_set[$urandom % $size(alu_set)];
		1: return md_set[$urandom % $size(md_set)];
		2: return mem_set[$urandom % $size(mem_set)];
		3: return br_set[$urandom % $size(br_set)];
		default: return exc_set[$urandom % $size(exc_set)];
	endcase
endfunction

function automatic logic [31:0] lead_count(input logic [31:0] x, input logic b);
	int n;
	n = 0;
	while (n < 32 && x[31 - n] == b)
		n++;
	return 32'(n);
endfunction

function automatic logic [31:0] shift_arith(input logic [31:0] x, input logic [4:0] n);
	logic [63:0] ext;
	ext = {{32{x[31]}}, x};
	return 32'(ext >> n);
endfunction

task automatic raise_exc(input logic [4:0] code);
	e_exc = 1'b1;
	e_code = code;
endtask

task automatic predict(input oper_t op, input logic [31:0] instr, input logic [31:0] pc,
		input logic [31:0] r1, input logic [31:0] r2);
	logic [31:0] simm;
	logic [31:0] pc4;
	logic [63:0] wide;
	longint      sa;
	longint      sb;
	logic        misaligned;
	simm = {{16{instr[15]}}, instr[15:0]};
	pc4 = pc + 32'd4;
	sa = longint'($signed(r1));
	sb = longint'($signed(r2));
	has_res = 1'b1;
	e_exc = 1'b0;
	e_code = 5'd0;
	e_extra = 32'd0;
	e_stall = 0;
	case (op)
		OP_AND: e_res = r1 & r2;
		OP_OR: e_res = r1 | r2;
		OP_XOR: e_res = r1 ^ r2;
		OP_NOR: e_res = ~(r1 | r2);
		OP_LUI: e_res = {instr[15:0], 16'h0000};
		OP_ADD, OP_ADDU: e_res = r1 + r2;
		OP_SUB, OP_SUBU: e_res = r1 - r2;
		OP_SLL: e_res = r2 << instr[10:6];
		OP_SLLV: e_res = r2 << r1[4:0];
		OP_SRL: e_res = r2 >> instr[10:6];
		OP_SRLV: e_res = r2 >> r1[4:0];
		OP_SRA: e_res = shift_arith(r2, instr[10:6]);
		OP_SRAV: e_res = shift_arith(r2, r1[4:0]);
		OP_SLT: e_res = {31'd0, sa < sb};
		OP_SLTU: e_res = {31'd0, r1 < r2};
		OP_CLZ: e_res = lead_count(r1, 1'b0);
		OP_CLO: e_res = lead_count(r1, 1'b1);
		OP_MOVZ, OP_MOVN: e_res = r1;
		OP_MFHI: e_res = m_hi;
		OP_MFLO: e_res = m_lo;
		OP_MUL: e_res = r1 * r2;
		OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL: e_res = pc + 32'd8;
		default: has_res = 1'b0;
	endcase
	case (op)
		OP_LUI, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: e_rd = instr[20:16];
		OP_JAL, OP_BLTZAL, OP_BGEZAL: e_rd = 5'd31;
		OP_MOVZ: e_rd = (r2 == 32'd0) ? instr[15:11] : 5'd0;
		OP_MOVN: e_rd = (r2 != 32'd0) ? instr[15:11] : 5'd0;
		default: e_rd = has_res ? instr[15:11] : 5'd0;
	endcase
	case (op)
		OP_INVALID: raise_exc(`EXCCODE_RI);
		OP_TEQ: if (r1 == r2) raise_exc(`EXCCODE_TR);
		OP_TNE: if (r1 != r2) raise_exc(`EXCCODE_TR);
		OP_TGE: if (sa >= sb) raise_exc(`EXCCODE_TR);
		OP_TLT: if (sa < sb) raise_exc(`EXCCODE_TR);
		OP_TGEU: if (r1 >= r2) raise_exc(`EXCCODE_TR);
		OP_TLTU: if (r1 < r2) raise_exc(`EXCCODE_TR);
		OP_SYSCALL: raise_exc(`EXCCODE_SYS);
		OP_BREAK: raise_exc(`EXCCODE_BP);
		OP_ADD: if (sa + sb != longint'($signed(r1 + r2))) raise_exc(`EXCCODE_OV);
		OP_SUB: if (sa - sb != longint'($signed(r1 - r2))) raise_exc(`EXCCODE_OV);
		default: ;
	endcase
	// byte lanes follow the low address bits
	e_addr = r1 + simm;
	if (op inside {OP_LB, OP_LBU, OP_SB}) begin
		e_be = 4'b0001 << e_addr[1:0];
		e_wdata = r2 << (8 * e_addr[1:0]);
		misaligned = 1'b0;
	end else if (op inside {OP_LH, OP_LHU, OP_SH}) begin
		e_be = e_addr[1] ? 4'b1100 : 4'b0011;
		e_wdata = r2 << (16 * e_addr[1]);
		misaligned = e_addr[0];
	end else begin
		e_be = 4'b1111;
		e_wdata = r2;
		misaligned = e_addr[1:0] != 2'b00;
	end
	use_mem = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW};
	is_store = op inside {OP_SB, OP_SH, OP_SW};
	e_read = use_mem && !is_store;
	e_write = is_store && !misaligned;
	if (use_mem && misaligned) begin
		raise_exc(is_store ? `EXCCODE_ADES : `EXCCODE_ADEL);
		e_extra = e_addr;
	end
	if (e_exc)
		e_rd = 5'd0;
	e_br_valid = op inside {OP_BEQ, OP_BNE, OP_BLTZ, OP_BGEZ, OP_BGTZ, OP_BLEZ,
		OP_BLTZAL, OP_BGEZAL, OP_J, OP_JAL, OP_JR, OP_JALR};
	e_target = pc4 + (simm << 2);
	e_taken = 1'b0;
	case (op)
		OP_BEQ: e_taken = r1 == r2;
		OP_BNE: e_taken = r1 != r2;
		OP_BLTZ, OP_BLTZAL: e_taken = sa < 0;
		OP_BGEZ, OP_BGEZAL: e_taken = sa >= 0;
		OP_BGTZ: e_taken = sa > 0;
		OP_BLEZ: e_taken = sa <= 0;
		OP_J, OP_JAL: begin
			e_taken = 1'b1;
			e_target = {pc4[31:28], instr[25:0], 2'b00};
		end
		OP_JR, OP_JALR: begin
			e_taken = 1'b1;
			e_target = r1;
		end
		default: ;
	endcase
	// HI/LO after the op completes
	case (op)
		OP_MTHI: m_hi = r1;
		OP_MTLO: m_lo = r1;
		OP_MULT, OP_MULTU: begin
			if (op == OP_MULT)
				wide = {{32{r1[31]}}, r1} * {{32{r2[31]}}, r2};
			else
				wide = {32'd0, r1} * {32'd0, r2};
			m_hi = wide[63:32];
			m_lo = wide[31:0];
			e_stall = 2;
		end
		OP_DIV: begin
			e_stall = `DIV_STEPS + 1;
			if (r2 != 32'd0) begin
				m_lo = 32'(sa / sb);
				m_hi = 32'(sa % sb);
			end
		end
		OP_DIVU: begin
			e_stall = `DIV_STEPS + 1;
			if (r2 != 32'd0) begin
				m_lo = r1 / r2;
				m_hi = r1 % r2;
			end
		end
		default: ;
	endcase
endtask

task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
	checks++;
	assert (act === exp)
	else begin
		errors++;
		$display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
	end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
	checks++;
	assert (act === exp)
	else begin
		errors++;
		$display("FAIL %s %s: expected %b, actual %b", cur_test, what, exp, act);
	end
endtask

task automatic compare_outputs();
	check_bit("out_valid", 1'b1, out_valid);
	check_bit("stall", e_stall != 0, stall);
	check_word("rd", 32'(e_rd), 32'(out_rd));
	check_bit("exc_valid", e_exc, out_exc_valid);
	if (e_exc)
		check_word("exc_code", 32'(e_code), 32'(out_exc_code));
	if (e_exc && use_mem)
		check_word("exc_extra", e_extra, out_exc_extra);
	if (has_res && !e_exc)
		check_word("result", e_res, out_result);
	check_bit("mem_write", e_write, out_mem_write);
	if (!e_exc)
		check_bit("mem_read", e_read, out_mem_read);
	if (use_mem) begin
		check_word("mem_addr", e_addr, out_mem_addr);
		if (!e_exc)
			check_word("mem_be", 32'(e_be), 32'(out_mem_be));
		if (is_store && !e_exc)
			check_word("mem_wdata", e_wdata, out_mem_wdata);
	end
	check_bit("br_valid", e_br_valid, out_br_valid);
	if (e_br_valid) begin
		check_bit("br_taken", e_taken, out_br_taken);
		check_word("br_target", e_target, out_br_target);
	end
endtask

// drives one op at 1 ns after an edge and returns 1 ns after its output edge
task automatic issue(input oper_t op, input logic [31:0] instr, input logic [31:0] pc,
		input logic [31:0] r1, input logic [31:0] r2);
	predict(op, instr, pc, r1, r2);
	in_valid = 1'b1;
	in_op = op;
	in_instr = instr;
	in_pc = pc;
	in_reg1 = r1;
	in_reg2 = r2;
	while (stall) begin
		@(posedge clk);
		#1;
		check_bit("out_valid while held", 1'b0, out_valid);
	end
	@(posedge clk);
	#1;
	in_valid = 1'b0;
	compare_outputs();
endtask

task automatic drain_stall();
	int n;
	n = 0;
	while (stall) begin
		@(posedge clk);
		#1;
		n++;
	end
	check_word("stall cycles", 32'(e_stall), 32'(n));
endtask

task automatic idle(input int cycles);
	in_valid = 1'b0;
	repeat (cycles) begin
		@(posedge clk);
		#1;
		check_bit("out_valid without accept", 1'b0, out_valid);
	end
endtask

task automatic run_test(input int kind, input string name);
	oper_t       op;
	logic [31:0] instr;
	logic [31:0] pc;
	logic [31:0] r1;
	logic [31:0] r2;
	int          start_checks;
	int          start_errors;
	cur_test = name;
	start_checks = checks;
	start_errors = errors;
	// known HI/LO before any MFHI/MFLO
	if (kind == 1) begin
		issue(OP_MTHI, $urandom, 32'h0040_0000, rand_operand(), 32'd0);
		issue(OP_MTLO, $urandom, 32'h0040_0004, rand_operand(), 32'd0);
	end
	for (int n = 0; n < N_OPS; n++) begin
		op = pick_op(kind);
		instr = $urandom;
		pc = $urandom & 32'hffff_fffc;
		r1 = rand_operand();
		r2 = ($urandom % 4 == 0) ? r1 : rand_operand();
		if (kind == 2 && $urandom % 2 == 1) begin
			instr[1:0] = 2'b00;
			r1[1:0] = 2'b00;
		end
		issue(op, instr, pc, r1, r2);
		if (kind == 1) begin
			if (e_stall != 0 && $urandom % 2 == 1)
				drain_stall();
			issue(OP_MFHI, $urandom, pc + 32'd4, rand_operand(), rand_operand());
			issue(OP_MFLO, $urandom, pc + 32'd8, rand_operand(), rand_operand());
		end
		if (kind == 5 && $urandom % 2 == 1)
			idle(int'($urandom % 3) + 1);
	end
	while (stall) begin
		@(posedge clk);
		#1;
	end
	$display("%s: %0d checks, %0d errors", name, checks - start_checks,
		errors - start_errors);
endtask

initial begin
	void'($urandom(43041));
	rst = 1'b1;
	in_valid = 1'b0;
	in_op = OP_INVALID;
	in_instr = 32'd0;
	in_pc = 32'd0;
	in_reg1 = 32'd0;
	in_reg2 = 32'd0;
	m_hi = 32'd0;
	m_lo = 32'd0;
	checks = 0;
	errors = 0;
	repeat (2) @(posedge clk);
	#1;
	rst = 1'b0;
	run_test(0, "alu_ops");
	run_test(1, "muldiv_hilo");
	run_test(2, "mem_requests");
	run_test(3, "branches");
	run_test(4, "exceptions");
	run_test(5, "back_to_back");
	$display("tests 6, checks %0d, errors %0d", checks, errors);
	if (errors == 0)
		$display("=== PASS ===");
	else
		$display("=== FAIL ===");
	$finish;
end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
verilog/cpu_pkg.sv
verilog/muldiv_if.sv
verilog/count_bit.sv
verilog/multi_cycle_exec.sv
verilog/branch_resolver.sv
verilog/instr_exec.sv
verilog/exec_stage_top.sv
verification/exec_stage_props.sv
verification/exec_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds and runs the execute stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=exec_stage_sim

verilator --binary --timing --assert -Mdir obj_dir -o "$BIN" \
	--top-module exec_stage_tb -f list.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
	exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0
